// File: verilog/local_mem_cfg.svh
// Local memory configuration: widths, bank geometry, bank timing and pipeline defaults
`ifndef LOCAL_MEM_CFG_SVH
`define LOCAL_MEM_CFG_SVH

// ====================
// Bus geometry
// ====================

// Word address width, 256 words in the bank
`define LOCAL_MEM_ADDR_WIDTH 8
`define LOCAL_MEM_DATA_WIDTH 32
// One enable per byte of the data word
`define LOCAL_MEM_BE_WIDTH 4

// ====================
// Buffering and timing
// ====================

// Entries in the accelerator-facing command FIFO
`define LOCAL_MEM_CMD_FIFO_DEPTH 4
// Minimum entries in the bank's input queue
`define LOCAL_MEM_QUEUE_DEPTH 16
// Cycles from service of a read to its data leaving the bank
`define LOCAL_MEM_READ_LATENCY 2
// Refresh repeats with this period and blocks service for the window length
`define LOCAL_MEM_REFRESH_INTERVAL 64
`define LOCAL_MEM_REFRESH_CYCLES 6

// Register stages inserted between the command buffer and the bank
`define LOCAL_MEM_SUGGESTED_REG_STAGES 2

`endif

// File: verilog/local_mem_pkg.sv
// Local memory package: address, data and byte-enable types shared by the memory RTL

`include "local_mem_cfg.svh"

package local_mem_pkg;

    // ====================
    // Bus field types
    // ====================

    // Word address into the bank
    typedef logic [`LOCAL_MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // One data word, the only transfer size on this port
    typedef logic [`LOCAL_MEM_DATA_WIDTH-1:0] mem_data_t;

    // Byte enables, bit b covers data bits 8*b+7 down to 8*b
    typedef logic [`LOCAL_MEM_BE_WIDTH-1:0] mem_be_t;

endpackage

// File: verilog/avalon_cmd_buffer.sv
// Avalon command buffer: absorbs waitrequest traffic and issues commands under almost-full

`include "local_mem_cfg.svh"

module avalon_cmd_buffer
    import local_mem_pkg::*;
(
    input  logic      tgt_mem_afu_clk,
    input  logic      reset,

    // Accelerator side, standard Avalon with waitrequest
    input  logic      read,
    input  logic      write,
    input  mem_addr_t address,
    input  mem_data_t writedata,
    input  mem_be_t   byteenable,
    output logic      waitrequest,

    // Pipeline side, no handshake beyond the delayed almost-full
    input  logic      almfull,
    output logic      cmd_valid,
    output logic      cmd_write,
    output mem_addr_t cmd_address,
    output mem_data_t cmd_writedata,
    output mem_be_t   cmd_byteenable
);

    localparam int DEPTH = `LOCAL_MEM_CMD_FIFO_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    // Command storage, one entry per accepted Avalon command
    logic      fifo_write [DEPTH];
    mem_addr_t fifo_address [DEPTH];
    mem_data_t fifo_writedata [DEPTH];
    mem_be_t   fifo_byteenable [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    // ====================
    // Waitrequest side
    // ====================

    // An Avalon command is taken on any cycle where waitrequest is low
    assign push = (read | write) & ~waitrequest;

    // ====================
    // Almost-full side
    // ====================

    // The head leaves only while the bank still reports room downstream
    // This is the point where waitrequest turns into the almost-full protocol
    assign pop = (count != '0) & ~almfull;

    always_comb
    begin
        count_next = count;
        if (push && !pop)
        begin
            count_next = count + 1'b1;
        end
        else if (!push && pop)
        begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            waitrequest <= 1'b0;
            cmd_valid   <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Registered, so it rises in the cycle after the last slot fills
            waitrequest <= (count_next == FULL_CNT);
            // The output register holds a command for exactly one cycle
            cmd_valid <= pop;
        end
    end

    // Payload path, qualified by the valid flags above
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (push)
        begin
            fifo_write[wr_ptr]      <= write;
            fifo_address[wr_ptr]    <= address;
            fifo_writedata[wr_ptr]  <= writedata;
            fifo_byteenable[wr_ptr] <= byteenable;
        end
        if (pop)
        begin
            cmd_write      <= fifo_write[rd_ptr];
            cmd_address    <= fifo_address[rd_ptr];
            cmd_writedata  <= fifo_writedata[rd_ptr];
            cmd_byteenable <= fifo_byteenable[rd_ptr];
        end
    end

endmodule

// File: verilog/avalon_reg_stage.sv
// Timing register stage: commands forward, read responses and almost-full backward

module avalon_reg_stage
    import local_mem_pkg::*;
(
    input  logic      tgt_mem_afu_clk,
    input  logic      reset,

    // Command path, buffer side in and bank side out
    input  logic      in_cmd_valid,
    input  logic      in_cmd_write,
    input  mem_addr_t in_cmd_address,
    input  mem_data_t in_cmd_writedata,
    input  mem_be_t   in_cmd_byteenable,
    output logic      out_cmd_valid,
    output logic      out_cmd_write,
    output mem_addr_t out_cmd_address,
    output mem_data_t out_cmd_writedata,
    output mem_be_t   out_cmd_byteenable,

    // Return path, bank side in and buffer side out
    input  logic      in_rsp_valid,
    input  mem_data_t in_rsp_data,
    input  logic      in_almfull,
    output logic      out_rsp_valid,
    output mem_data_t out_rsp_data,
    output logic      out_almfull
);

    // No stall logic here, the bank reserves room for whatever is in flight
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (reset)
        begin
            out_cmd_valid <= 1'b0;
            out_rsp_valid <= 1'b0;
            out_almfull   <= 1'b0;
        end
        else
        begin
            out_cmd_valid <= in_cmd_valid;
            out_rsp_valid <= in_rsp_valid;
            out_almfull   <= in_almfull;
        end
    end

    // Payload registers follow their valid bits
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        out_cmd_write      <= in_cmd_write;
        out_cmd_address    <= in_cmd_address;
        out_cmd_writedata  <= in_cmd_writedata;
        out_cmd_byteenable <= in_cmd_byteenable;
        out_rsp_data       <= in_rsp_data;
    end

endmodule

// File: verilog/local_mem_bank.sv
// Local memory bank model: queued commands, refresh stalls, byte writes, fixed-latency reads

`include "local_mem_cfg.svh"

module local_mem_bank
    import local_mem_pkg::*;
#(
    // Free queue slots at or below which almfull is raised
    parameter int ALMFULL_SLOTS = 7
)
(
    input  logic      tgt_mem_afu_clk,
    input  logic      reset,
    input  logic      cmd_valid,
    input  logic      cmd_write,
    input  mem_addr_t cmd_address,
    input  mem_data_t cmd_writedata,
    input  mem_be_t   cmd_byteenable,
    output logic      rsp_valid,
    output mem_data_t rsp_data,
    output logic      almfull
);

    // The queue grows past the nominal depth when deep pipelines need a larger reserve
    localparam int QDEPTH = (`LOCAL_MEM_QUEUE_DEPTH > ALMFULL_SLOTS + 4) ?
                            `LOCAL_MEM_QUEUE_DEPTH : ALMFULL_SLOTS + 4;
    localparam int QCNT_W = $clog2(QDEPTH + 1);
    localparam int QPTR_W = $clog2(QDEPTH);
    localparam logic [QPTR_W-1:0] QPTR_LAST = QPTR_W'(QDEPTH - 1);
    localparam logic [QCNT_W-1:0] ALMFULL_LEVEL = QCNT_W'(QDEPTH - ALMFULL_SLOTS);
    localparam int LAT = `LOCAL_MEM_READ_LATENCY;
    localparam int RCNT_W = $clog2(`LOCAL_MEM_REFRESH_INTERVAL);
    localparam logic [RCNT_W-1:0] REFRESH_LAST = RCNT_W'(`LOCAL_MEM_REFRESH_INTERVAL - 1);
    localparam logic [RCNT_W-1:0] REFRESH_START =
        RCNT_W'(`LOCAL_MEM_REFRESH_INTERVAL - `LOCAL_MEM_REFRESH_CYCLES);

    mem_data_t mem [1 << `LOCAL_MEM_ADDR_WIDTH];

    // Input queue
    logic      q_write [QDEPTH];
    mem_addr_t q_address [QDEPTH];
    mem_data_t q_writedata [QDEPTH];
    mem_be_t   q_byteenable [QDEPTH];
    logic [QPTR_W-1:0] q_wr_ptr;
    logic [QPTR_W-1:0] q_rd_ptr;
    logic [QCNT_W-1:0] q_count;
    logic [QCNT_W-1:0] q_count_next;

    logic [RCNT_W-1:0] refresh_cnt;
    logic              refresh_active;
    logic              svc;

    // Read latency pipe, index LAT-1 is the bank output
    logic      rd_valid [LAT];
    mem_data_t rd_data [LAT];

    // ====================
    // Queue and refresh
    // ====================

    // Refresh occupies the last cycles of every interval
    assign refresh_active = (refresh_cnt >= REFRESH_START);
    assign svc = (q_count != '0) & ~refresh_active;

    always_comb
    begin
        q_count_next = q_count;
        if (cmd_valid && !svc)
        begin
            q_count_next = q_count + 1'b1;
        end
        else if (!cmd_valid && svc)
        begin
            q_count_next = q_count - 1'b1;
        end
    end

    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (reset)
        begin
            q_wr_ptr    <= '0;
            q_rd_ptr    <= '0;
            q_count     <= '0;
            refresh_cnt <= '0;
            almfull     <= 1'b0;
            for (int i = 0; i < LAT; i++)
            begin
                rd_valid[i] <= 1'b0;
            end
        end
        else
        begin
            if (cmd_valid)
            begin
                q_wr_ptr <= (q_wr_ptr == QPTR_LAST) ? '0 : q_wr_ptr + 1'b1;
            end
            if (svc)
            begin
                q_rd_ptr <= (q_rd_ptr == QPTR_LAST) ? '0 : q_rd_ptr + 1'b1;
            end
            q_count     <= q_count_next;
            refresh_cnt <= (refresh_cnt == REFRESH_LAST) ? '0 : refresh_cnt + 1'b1;
            // Free slots at or below the reserve, so stop the buffer upstream
            almfull <= (q_count_next >= ALMFULL_LEVEL);
            rd_valid[0] <= svc & ~q_write[q_rd_ptr];
            for (int i = 1; i < LAT; i++)
            begin
                rd_valid[i] <= rd_valid[i-1];
            end
        end
    end

    // ====================
    // Array and read pipe
    // ====================

    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (cmd_valid)
        begin
            q_write[q_wr_ptr]      <= cmd_write;
            q_address[q_wr_ptr]    <= cmd_address;
            q_writedata[q_wr_ptr]  <= cmd_writedata;
            q_byteenable[q_wr_ptr] <= cmd_byteenable;
        end
        // Writes only touch the enabled bytes, the rest of the word is kept
        if (svc && q_write[q_rd_ptr])
        begin
            for (int b = 0; b < `LOCAL_MEM_BE_WIDTH; b++)
            begin
                if (q_byteenable[q_rd_ptr][b])
                begin
                    mem[q_address[q_rd_ptr]][8*b +: 8] <= q_writedata[q_rd_ptr][8*b +: 8];
                end
            end
        end
        rd_data[0] <= mem[q_address[q_rd_ptr]];
        for (int i = 1; i < LAT; i++)
        begin
            rd_data[i] <= rd_data[i-1];
        end
    end

    assign rsp_valid = rd_valid[LAT-1];
    assign rsp_data  = rd_data[LAT-1];

endmodule

// File: verilog/local_mem_as_avalon.sv
// Local memory exported as an Avalon slave through a command buffer and register stages

`include "local_mem_cfg.svh"

module local_mem_as_avalon
    import local_mem_pkg::*;
#(
    // Register stages between the command buffer and the bank, 0 to 8
    parameter int N_REG_STAGES = `LOCAL_MEM_SUGGESTED_REG_STAGES
)
(
    input  logic      tgt_mem_afu_clk,
    input  logic      reset,
    input  logic      read,
    input  logic      write,
    input  mem_addr_t address,
    input  mem_data_t writedata,
    input  mem_be_t   byteenable,
    output logic      waitrequest,
    output mem_data_t readdata,
    output logic      readdatavalid
);

    // ====================
    // Almost-full reserve
    // ====================

    // Commands in flight when almfull rises: the return trip and the forward trip
    // through the stages, the buffer's output register, and two spare slots
    localparam int ALMFULL_SLOTS = 2 * N_REG_STAGES + 1 + 2;

    // Index 0 faces the command buffer, index N_REG_STAGES faces the bank
    logic      cmd_valid_w [N_REG_STAGES+1];
    logic      cmd_write_w [N_REG_STAGES+1];
    mem_addr_t cmd_address_w [N_REG_STAGES+1];
    mem_data_t cmd_writedata_w [N_REG_STAGES+1];
    mem_be_t   cmd_byteenable_w [N_REG_STAGES+1];
    logic      rsp_valid_w [N_REG_STAGES+1];
    mem_data_t rsp_data_w [N_REG_STAGES+1];
    logic      almfull_w [N_REG_STAGES+1];

    avalon_cmd_buffer cmd_buf_i
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .read            (read),
        .write           (write),
        .address         (address),
        .writedata       (writedata),
        .byteenable      (byteenable),
        .waitrequest     (waitrequest),
        .almfull         (almfull_w[0]),
        .cmd_valid       (cmd_valid_w[0]),
        .cmd_write       (cmd_write_w[0]),
        .cmd_address     (cmd_address_w[0]),
        .cmd_writedata   (cmd_writedata_w[0]),
        .cmd_byteenable  (cmd_byteenable_w[0])
    );

    // Plain pipeline, every stage adds one cycle in each direction
    for (genvar i = 0; i < N_REG_STAGES; i++)
    begin : stage_g
        avalon_reg_stage stage_i
        (
            .tgt_mem_afu_clk    (tgt_mem_afu_clk),
            .reset              (reset),
            .in_cmd_valid       (cmd_valid_w[i]),
            .in_cmd_write       (cmd_write_w[i]),
            .in_cmd_address     (cmd_address_w[i]),
            .in_cmd_writedata   (cmd_writedata_w[i]),
            .in_cmd_byteenable  (cmd_byteenable_w[i]),
            .out_cmd_valid      (cmd_valid_w[i+1]),
            .out_cmd_write      (cmd_write_w[i+1]),
            .out_cmd_address    (cmd_address_w[i+1]),
            .out_cmd_writedata  (cmd_writedata_w[i+1]),
            .out_cmd_byteenable (cmd_byteenable_w[i+1]),
            .in_rsp_valid       (rsp_valid_w[i+1]),
            .in_rsp_data        (rsp_data_w[i+1]),
            .in_almfull         (almfull_w[i+1]),
            .out_rsp_valid      (rsp_valid_w[i]),
            .out_rsp_data       (rsp_data_w[i]),
            .out_almfull        (almfull_w[i])
        );
    end

    local_mem_bank #(
        .ALMFULL_SLOTS (ALMFULL_SLOTS)
    ) bank_i
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .cmd_valid       (cmd_valid_w[N_REG_STAGES]),
        .cmd_write       (cmd_write_w[N_REG_STAGES]),
        .cmd_address     (cmd_address_w[N_REG_STAGES]),
        .cmd_writedata   (cmd_writedata_w[N_REG_STAGES]),
        .cmd_byteenable  (cmd_byteenable_w[N_REG_STAGES]),
        .rsp_valid       (rsp_valid_w[N_REG_STAGES]),
        .rsp_data        (rsp_data_w[N_REG_STAGES]),
        .almfull         (almfull_w[N_REG_STAGES])
    );

    // Responses come back in command order with no back-pressure
    assign readdatavalid = rsp_valid_w[0];
    assign readdata      = rsp_data_w[0];

endmodule

// File: dv/local_mem_assert.sv
// Protocol and reset assertions bound into the Avalon local memory top level

`include "local_mem_cfg.svh"

module local_mem_assert
    import local_mem_pkg::*;
#(
    parameter int ALMFULL_SLOTS = 7,
    // The bank grows its queue past the nominal depth for deep pipelines
    parameter int QUEUE_DEPTH = (`LOCAL_MEM_QUEUE_DEPTH > ALMFULL_SLOTS + 4) ?
                                `LOCAL_MEM_QUEUE_DEPTH : ALMFULL_SLOTS + 4
)
(
    input logic      tgt_mem_afu_clk,
    input logic      reset,
    input logic      read,
    input logic      write,
    input mem_addr_t address,
    input mem_data_t writedata,
    input mem_be_t   byteenable,
    input logic      waitrequest,
    input logic      readdatavalid,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0] q_count
);

    // A stalled master keeps its whole command on the bus
    cmd_held_a: assert property (
        @(posedge tgt_mem_afu_clk) disable iff (reset)
        (waitrequest && (read || write)) |=>
            ($stable(read) && $stable(write) && $stable(address) &&
             $stable(writedata) && $stable(byteenable))
    ) else $error("command inputs changed while waitrequest was high");

    // No read data during reset or in the first cycle out of it
    rdv_in_reset_a: assert property (
        @(posedge tgt_mem_afu_clk) reset |=> !readdatavalid
    ) else $error("readdatavalid high during or right after reset");

    wait_in_reset_a: assert property (
        @(posedge tgt_mem_afu_clk) reset |=> !waitrequest
    ) else $error("waitrequest high out of reset");

    // The almost-full reserve must cover every command in flight
    queue_bound_a: assert property (
        @(posedge tgt_mem_afu_clk) disable iff (reset) q_count <= QUEUE_DEPTH
    ) else $error("bank input queue overflowed");

endmodule

bind local_mem_as_avalon local_mem_assert #(
    .ALMFULL_SLOTS (ALMFULL_SLOTS)
) assert_i
(
    .tgt_mem_afu_clk (tgt_mem_afu_clk),
    .reset           (reset),
    .read            (read),
    .write           (write),
    .address         (address),
    .writedata       (writedata),
    .byteenable      (byteenable),
    .waitrequest     (waitrequest),
    .readdatavalid   (readdatavalid),
    .q_count         (bank_i.q_count)
);

// File: dv/local_mem_tb.sv
// Testbench that drives the Avalon local memory port from a vectors file and checks read data

module local_mem_tb
    import local_mem_pkg::*;
();

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 500;
    // Back-to-back replays of the vector table after the first paced pass
    localparam int BURST_PASSES   = 8;

    logic      tgt_mem_afu_clk;
    logic      reset;
    logic      read;
    logic      write;
    mem_addr_t address;
    mem_data_t writedata;
    mem_be_t   byteenable;
    logic      waitrequest;
    mem_data_t readdata;
    logic      readdatavalid;

    // One vector table entry per command line of the file
    byte       vec_op [$];
    mem_addr_t vec_addr [$];
    mem_data_t vec_wdata [$];
    mem_be_t   vec_be [$];
    mem_data_t vec_exp [$];
    int        file_reads;

    // Expected read data still owed by the DUT with the oldest first
    mem_data_t exp_q [$];
    logic      saw_wait;
    logic [31:0] lfsr;

    local_mem_as_avalon dut_i
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .read            (read),
        .write           (write),
        .address         (address),
        .writedata       (writedata),
        .byteenable      (byteenable),
        .waitrequest     (waitrequest),
        .readdata        (readdata),
        .readdatavalid   (readdatavalid)
    );

    always #50 tgt_mem_afu_clk = ~tgt_mem_afu_clk;

    // ====================
    // Reporting
    // ====================

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ====================
    // Stimulus helpers
    // ====================

    // Right-shifting Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // Two fresh LFSR bits give an idle gap of 0 to 3 cycles
    task automatic draw_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++)
        begin
            lfsr = lfsr_next(lfsr);
            gap = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic idle_cycles(input int n);
        read  = 1'b0;
        write = 1'b0;
        repeat (n)
        begin
            @(posedge tgt_mem_afu_clk);
            #10;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        byte         op;
        int unsigned f_addr;
        int unsigned f_data;
        int unsigned f_be;
        int unsigned f_exp;
        file_reads = 0;
        fd = $fopen("dv/local_mem_vectors.txt", "r");
        if (fd == 0)
        begin
            report_failure("the vectors file could not be opened");
        end
        while ($fgets(line, fd) != 0)
        begin
            // Blank lines and comment lines carry no command
            if (line.len() > 1 && line[0] != "#")
            begin
                n = $sscanf(line, "%c %h %h %h %h", op, f_addr, f_data, f_be, f_exp);
                if (n != 5 || (op != "R" && op != "W"))
                begin
                    report_failure("a line of the vectors file could not be parsed");
                end
                vec_op.push_back(op);
                vec_addr.push_back(mem_addr_t'(f_addr));
                vec_wdata.push_back(mem_data_t'(f_data));
                vec_be.push_back(mem_be_t'(f_be));
                vec_exp.push_back(mem_data_t'(f_exp));
                if (op == "R")
                begin
                    file_reads++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Drive one command and hold it until the port takes it
    task automatic issue_cmd(input int idx);
        int   waited;
        logic taken;
        waited     = 0;
        taken      = 1'b0;
        read       = (vec_op[idx] == "R");
        write      = (vec_op[idx] == "W");
        address    = vec_addr[idx];
        writedata  = vec_wdata[idx];
        byteenable = vec_be[idx];
        while (!taken)
        begin
            if (waited >= ACCEPT_TIMEOUT)
            begin
                report_failure("the DUT stopped responding, a command was never accepted");
            end
            // Registered waitrequest is stable here and decides the coming edge
            taken = (waitrequest == 1'b0);
            if (waitrequest)
            begin
                saw_wait = 1'b1;
            end
            @(posedge tgt_mem_afu_clk);
            #10;
            waited++;
        end
        if (vec_op[idx] == "R")
        begin
            exp_q.push_back(vec_exp[idx]);
        end
    endtask

    task automatic run_pass(input logic with_gaps);
        int gap;
        for (int i = 0; i < vec_op.size(); i++)
        begin
            issue_cmd(i);
            if (with_gaps)
            begin
                draw_gap(gap);
                idle_cycles(gap);
            end
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            if (waited >= DRAIN_TIMEOUT)
            begin
                report_failure("the DUT stopped responding, read data never came back");
            end
            @(posedge tgt_mem_afu_clk);
            waited++;
        end
    endtask

    // ====================
    // Response monitor
    // ====================

    // Outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge tgt_mem_afu_clk)
    begin
        if (!reset && readdatavalid)
        begin
            if (exp_q.size() == 0)
            begin
                report_failure("read data arrived while no read was outstanding");
            end
            check_value("readdata", readdata, exp_q.pop_front());
        end
    end

    initial
    begin
        tgt_mem_afu_clk = 1'b0;
        reset      = 1'b1;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        byteenable = '0;
        saw_wait   = 1'b0;
        lfsr       = 32'h9cf8_fc71;
        load_vectors();

        repeat (5) @(posedge tgt_mem_afu_clk);
        #10;
        reset = 1'b0;
        check_value("readdatavalid", 32'(readdatavalid), 32'd0);
        check_value("waitrequest", 32'(waitrequest), 32'd0);

        // A paced pass comes first and then a long unbroken run across refresh windows
        run_pass(1'b1);
        for (int p = 0; p < BURST_PASSES; p++)
        begin
            run_pass(1'b0);
        end
        idle_cycles(0);
        wait_for_drain();

        // Quiet window so that a stray response would still be caught
        repeat (20) @(posedge tgt_mem_afu_clk);
        check_value("waitrequest_seen", 32'(saw_wait), 32'd1);
        $display("test passed");
        $finish;
    end

endmodule

// File: dv/local_mem_vectors.txt
# op addr wdata be expected, all hex; W writes under byte enable, R reads back
# R expects the byte-enable merge of all earlier writes to that address
W 00 11223344 f 00000000
R 00 00000000 0 11223344
W 10 deadbeef f 00000000
W 10 0000a5a5 3 00000000
R 10 00000000 0 deada5a5
W 20 cafef00d f 00000000
W 20 77000000 8 00000000
W 20 00990000 4 00000000
R 20 00000000 0 7799f00d
W 31 01234567 f 00000000
W 31 89abcdef 5 00000000
R 31 00000000 0 01ab45ef
W 42 a0b0c0d0 f 00000000
R 42 00000000 0 a0b0c0d0
W 42 0000e000 2 00000000
R 42 00000000 0 a0b0e0d0
R 00 00000000 0 11223344
W 55 5555aaaa f 00000000
W 66 66669999 f 00000000
R 55 00000000 0 5555aaaa
R 66 00000000 0 66669999
W 00 ffffffff 9 00000000
R 00 00000000 0 ff2233ff
R 10 00000000 0 deada5a5

// File: sources.f
+incdir+verilog
verilog/local_mem_pkg.sv
verilog/avalon_cmd_buffer.sv
verilog/avalon_reg_stage.sv
verilog/local_mem_bank.sv
verilog/local_mem_as_avalon.sv
dv/local_mem_assert.sv
dv/local_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the local memory testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module local_mem_tb \
    -f sources.f -o local_mem_sim &&
./obj_dir/local_mem_sim | tee /dev/stderr | grep -x "test passed" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
